/* hw/dbg_pkg.sv */
package dbg_pkg;

    // ------------------------------------------------------------------------
    // architectural constants
    // ------------------------------------------------------------------------
    localparam int NUM_BP     = 4;   // DR0..DR3
    localparam int DR7_RW_LSB = 16;  // RW0 field, then LEN0, RW1, LEN1 ...

    localparam logic [1:0] RW_EXEC  = 2'b00;  // instruction execution
    localparam logic [1:0] RW_WRITE = 2'b01;  // data writes only

    // register word indices on the wishbone port
    localparam int DR6_IDX = 6;
    localparam int DR7_IDX = 7;

    localparam int DR6_STEP_BIT = 14;  // BS
    localparam int DR6_TASK_BIT = 15;  // BT
    localparam logic [31:0] DR6_IMPL = 32'h0000_c00f;  // writable status bits

    // ------------------------------------------------------------------------
    // shared records
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [NUM_BP-1:0][31:0] bp_addr;   // linear addresses DR0..DR3
        logic [31:0]             dr7;
        logic [NUM_BP-1:0][2:0]  len_mask;  // low address bits ignored
    } dbg_cfg_t;

    typedef struct packed {
        logic        wr_finished;
        logic        w_load;
        logic        inhibit;             // interrupt/debug shadow
        logic        trap_clear;
        logic        task_trigger;        // T bit of new task
        logic        string_in_progress;
        logic        rflag;
        logic        tflag;
        logic [31:0] eip;
        logic [31:0] cs_base;
    } retire_t;

    typedef struct packed {
        logic [31:0] write_address;
        logic [2:0]  write_length;  // bytes, 1..4
        logic        write_ready;
    } mem_wr_t;

    typedef struct packed {
        logic [NUM_BP-1:0] code;
        logic [NUM_BP-1:0] write;
        logic [NUM_BP-1:0] read;
        logic              step;
        logic              task_sw;
    } dbg_event_t;

    // ------------------------------------------------------------------------
    // DR7 field access
    // ------------------------------------------------------------------------
    function automatic logic [1:0] bp_rw(input logic [31:0] dr7, input int idx);
        return dr7[DR7_RW_LSB + 4*idx +: 2];
    endfunction

    function automatic logic [1:0] bp_len(input logic [31:0] dr7, input int idx);
        return dr7[DR7_RW_LSB + 4*idx + 2 +: 2];
    endfunction

    // local or global enable
    function automatic logic bp_enabled(input logic [31:0] dr7, input int idx);
        return |dr7[2*idx +: 2];
    endfunction

endpackage

/* hw/dbg_regs.sv */
`timescale 1ns/100ps

module dbg_regs #(
    parameter int ADDR_W = 5
) (
    input  logic                clk,
    input  logic                rst_n,
    // wishbone classic slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [ADDR_W-1:0]   wb_adr,
    input  logic [31:0]         wb_dat_w,
    input  logic [3:0]          wb_sel,
    output logic [31:0]         wb_dat_r,
    output logic                wb_ack,
    // event capture
    input  logic                debug_prepare_q,
    input  dbg_pkg::dbg_event_t debug_event,
    // decoded configuration
    output dbg_pkg::dbg_cfg_t   cfg
);

    localparam int WORD_W = ADDR_W - 2;  // word index from the byte address

    logic [WORD_W-1:0]                   word_adr;
    logic                                wr_en;
    logic [dbg_pkg::NUM_BP-1:0][31:0]    dr_addr;
    logic [31:0]                         dr6;
    logic [31:0]                         dr7;
    logic [31:0]                         dr6_set;
    logic [31:0]                         dr6_base;
    logic [31:0]                         rd_data;

    // byte lane merge under sel
    function automatic logic [31:0] lane_merge(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  sel);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = new_val[8*b +: 8];
        end
        return res;
    endfunction

    // LEN field to ignored low bits
    function automatic logic [2:0] len_to_mask(input logic [1:0] len);
        case (len)
            2'b00:   return 3'd0;  // 1 byte
            2'b01:   return 3'd1;  // 2 bytes
            2'b11:   return 3'd3;  // 4 bytes
            default: return 3'd7;  // 8 bytes
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // wishbone handshake
    // ------------------------------------------------------------------------
    assign word_adr = wb_adr[ADDR_W-1:2];
    assign wr_en    = wb_ack && wb_cyc && wb_stb && wb_we;  // commit in ack cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;  // single cycle ack
        end
    end

    // ------------------------------------------------------------------------
    // register file
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dr_addr <= '0;
            dr7     <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < dbg_pkg::NUM_BP; i++) begin
                if (word_adr == WORD_W'(i)) dr_addr[i] <= lane_merge(dr_addr[i], wb_dat_w, wb_sel);
            end
            if (word_adr == WORD_W'(dbg_pkg::DR7_IDX)) dr7 <= lane_merge(dr7, wb_dat_w, wb_sel);
        end
    end

    // status bits from last event
    always_comb begin
        dr6_set = '0;
        dr6_set[dbg_pkg::NUM_BP-1:0] = debug_event.code | debug_event.write | debug_event.read;
        dr6_set[dbg_pkg::DR6_STEP_BIT] = debug_event.step;
        dr6_set[dbg_pkg::DR6_TASK_BIT] = debug_event.task_sw;
    end

    // software write first with event bits ORed on top
    assign dr6_base = (wr_en && word_adr == WORD_W'(dbg_pkg::DR6_IDX)) ?
                      (lane_merge(dr6, wb_dat_w, wb_sel) & dbg_pkg::DR6_IMPL) : dr6;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dr6 <= '0;
        end else begin
            dr6 <= debug_prepare_q ? (dr6_base | dr6_set) : dr6_base;  // sticky
        end
    end

    // read mux with zero for unmapped words
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < dbg_pkg::NUM_BP; i++) begin
            if (word_adr == WORD_W'(i)) rd_data = dr_addr[i];
        end
        if (word_adr == WORD_W'(dbg_pkg::DR6_IDX)) rd_data = dr6;
        if (word_adr == WORD_W'(dbg_pkg::DR7_IDX)) rd_data = dr7;
    end

    assign wb_dat_r = wb_ack ? rd_data : '0;

    // ------------------------------------------------------------------------
    // configuration out
    // ------------------------------------------------------------------------
    always_comb begin
        cfg.bp_addr = dr_addr;
        cfg.dr7     = dr7;
        for (int i = 0; i < dbg_pkg::NUM_BP; i++) begin
            cfg.len_mask[i] = len_to_mask(dbg_pkg::bp_len(dr7, i));
        end
    end

    // master holds its request until the ack
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_stb && !wb_ack |=>
            wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we))
        else $error("wishbone request dropped or changed before ack");

endmodule

/* hw/bp_match.sv */
`timescale 1ns/100ps

module bp_match (
    input  logic                        clk,
    input  logic                        rst_n,
    input  dbg_pkg::dbg_cfg_t           cfg,
    input  dbg_pkg::mem_wr_t            mem_wr,
    input  logic [31:0]                 code_linear,
    output logic [dbg_pkg::NUM_BP-1:0]  write_hit,
    output logic [dbg_pkg::NUM_BP-1:0]  code_hit
);

    logic [31:0]                        wr_start_q;  // first byte of write
    logic [31:0]                        wr_last_q;   // last byte of write
    logic [dbg_pkg::NUM_BP-1:0][31:0]   span_lo;
    logic [dbg_pkg::NUM_BP-1:0][31:0]   span_hi;
    logic [dbg_pkg::NUM_BP-1:0]         write_hit_d;

    // ------------------------------------------------------------------------
    // write range registered ahead of write_ready
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        wr_start_q <= mem_wr.write_address;
        wr_last_q  <= mem_wr.write_address + 32'(mem_wr.write_length) - 32'd1;
    end

    // aligned span of each breakpoint
    always_comb begin
        for (int i = 0; i < dbg_pkg::NUM_BP; i++) begin
            span_lo[i] = cfg.bp_addr[i] & ~{29'd0, cfg.len_mask[i]};
            span_hi[i] = cfg.bp_addr[i] | {29'd0, cfg.len_mask[i]};
        end
    end

    // ------------------------------------------------------------------------
    // comparators
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < dbg_pkg::NUM_BP; i++) begin
            // ranges overlap
            write_hit_d[i] = dbg_pkg::bp_rw(cfg.dr7, i) == dbg_pkg::RW_WRITE &&
                             wr_start_q <= span_hi[i] &&
                             wr_last_q  >= span_lo[i];
            // same aligned address without enable gating
            code_hit[i] = dbg_pkg::bp_rw(cfg.dr7, i) == dbg_pkg::RW_EXEC &&
                          (code_linear & ~{29'd0, cfg.len_mask[i]}) == span_lo[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_hit <= '0;
        end else begin
            write_hit <= mem_wr.write_ready ? write_hit_d : '0;  // one cycle behind ready
        end
    end

    // registered range must match the write that raised ready
    a_addr_settled: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_wr.write_ready) |->
            $stable(mem_wr.write_address) && $stable(mem_wr.write_length))
        else $error("write address moved as write_ready rose");

endmodule

/* hw/write_debug.sv */
`timescale 1ns/100ps

module write_debug (
    input  logic                        clk,
    input  logic                        rst_n,
    input  dbg_pkg::dbg_cfg_t           cfg,
    input  dbg_pkg::retire_t            retire,
    input  dbg_pkg::mem_wr_t            mem_wr,
    input  logic [31:0]                 cs_limit,
    input  logic [dbg_pkg::NUM_BP-1:0]  exe_debug_read,  // execute stage read hits
    output logic                        debug_prepare,
    output logic                        debug_prepare_q,
    output dbg_pkg::dbg_event_t         debug_event
);

    logic                           bp_disabled;
    logic [dbg_pkg::NUM_BP-1:0]     bp_en;
    logic [31:0]                    code_linear;
    logic [dbg_pkg::NUM_BP-1:0]     write_hit;
    logic [dbg_pkg::NUM_BP-1:0]     code_hit;

    logic [dbg_pkg::NUM_BP-1:0]     read_cur;
    logic [dbg_pkg::NUM_BP-1:0]     read_acc;
    logic [dbg_pkg::NUM_BP-1:0]     read_act;
    logic [dbg_pkg::NUM_BP-1:0]     write_cur;
    logic [dbg_pkg::NUM_BP-1:0]     write_acc;
    logic [dbg_pkg::NUM_BP-1:0]     write_all;
    logic [dbg_pkg::NUM_BP-1:0]     write_act;
    logic                           code_ok;
    logic [dbg_pkg::NUM_BP-1:0]     code_act;
    logic                           step_pending;

    // ------------------------------------------------------------------------
    // enables
    // ------------------------------------------------------------------------
    assign bp_disabled = cfg.dr7[7:0] == 8'h00;  // no L/G bit set at all

    always_comb begin
        for (int i = 0; i < dbg_pkg::NUM_BP; i++) begin
            bp_en[i] = dbg_pkg::bp_enabled(cfg.dr7, i);
        end
    end

    assign code_linear = retire.cs_base + retire.eip;

    bp_match i_bp_match (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .mem_wr      (mem_wr),
        .code_linear (code_linear),
        .write_hit   (write_hit),
        .code_hit    (code_hit)
    );

    // ------------------------------------------------------------------------
    // read hits
    // ------------------------------------------------------------------------
    assign read_cur = bp_disabled ? '0 : exe_debug_read;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_acc <= '0;
        end else if (retire.inhibit || debug_prepare) begin
            read_acc <= read_acc;  // keep for event
        end else if (retire.trap_clear) begin
            read_acc <= '0;
        end else if (retire.wr_finished) begin
            read_acc <= retire.w_load ? read_cur : '0;  // next instruction starts here
        end else if (retire.w_load) begin
            read_acc <= read_acc | read_cur;
        end
    end

    assign read_act = read_acc & bp_en;

    // ------------------------------------------------------------------------
    // write hits
    // ------------------------------------------------------------------------
    assign write_cur = bp_disabled ? '0 : write_hit;
    assign write_all = write_cur | write_acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_acc <= '0;
        end else if (retire.inhibit) begin
            write_acc <= write_acc;
        end else if (retire.trap_clear) begin
            write_acc <= '0;
        end else if (mem_wr.write_ready || debug_prepare) begin
            write_acc <= write_all;  // collect while writes run
        end else if (retire.wr_finished) begin
            write_acc <= '0;
        end
    end

    assign write_act = write_all & bp_en;

    // ------------------------------------------------------------------------
    // code breakpoints at retire
    // ------------------------------------------------------------------------
    assign code_ok = retire.wr_finished &&
                     retire.eip <= cs_limit &&       // inside segment
                     !retire.rflag &&                // resume flag masks
                     !retire.string_in_progress &&
                     !bp_disabled;

    assign code_act = code_ok ? (code_hit & bp_en) : '0;

    // ------------------------------------------------------------------------
    // single step
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_pending <= 1'b0;
        end else if (retire.trap_clear) begin
            step_pending <= 1'b0;
        end else if (retire.wr_finished) begin
            step_pending <= retire.tflag;  // trap after the next instruction
        end
    end

    // ------------------------------------------------------------------------
    // prepare and event record
    // ------------------------------------------------------------------------
    assign debug_prepare = retire.wr_finished && !retire.inhibit &&
                           (retire.task_trigger || step_pending || (|code_act) ||
                            (|read_act) || (|write_act));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debug_event     <= '0;
            debug_prepare_q <= 1'b0;
        end else begin
            debug_prepare_q <= debug_prepare;  // DR6 capture strobe
            if (debug_prepare) begin
                debug_event.code    <= code_act;
                debug_event.write   <= write_act;
                debug_event.read    <= read_act;
                debug_event.step    <= step_pending;
                debug_event.task_sw <= retire.task_trigger;
            end
        end
    end

    // write hits stay collected until the instruction finishes
    a_ready_to_finish: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_wr.write_ready) |-> $past(retire.wr_finished))
        else $error("write_ready dropped before the finish cycle");

endmodule

/* hw/debug_unit_top.sv */
`timescale 1ns/100ps

module debug_unit_top #(
    parameter int ADDR_W = 5
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // register access
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [ADDR_W-1:0]           wb_adr,
    input  logic [31:0]                 wb_dat_w,
    input  logic [3:0]                  wb_sel,
    output logic [31:0]                 wb_dat_r,
    output logic                        wb_ack,
    // pipeline side
    input  dbg_pkg::retire_t            retire,
    input  dbg_pkg::mem_wr_t            mem_wr,
    input  logic [31:0]                 cs_limit,
    input  logic [dbg_pkg::NUM_BP-1:0]  exe_debug_read,
    output logic                        debug_prepare,
    output dbg_pkg::dbg_event_t         debug_event
);

    dbg_pkg::dbg_cfg_t  cfg;
    logic               debug_prepare_q;  // DR6 capture strobe

    // ------------------------------------------------------------------------
    dbg_regs #(
        .ADDR_W (ADDR_W)
    ) i_dbg_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_w        (wb_dat_w),
        .wb_sel          (wb_sel),
        .wb_dat_r        (wb_dat_r),
        .wb_ack          (wb_ack),
        .debug_prepare_q (debug_prepare_q),
        .debug_event     (debug_event),
        .cfg             (cfg)
    );

    write_debug i_write_debug (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg             (cfg),
        .retire          (retire),
        .mem_wr          (mem_wr),
        .cs_limit        (cs_limit),
        .exe_debug_read  (exe_debug_read),
        .debug_prepare   (debug_prepare),
        .debug_prepare_q (debug_prepare_q),
        .debug_event     (debug_event)
    );

endmodule

/* test/tb_debug_unit.sv */
`timescale 1ns/100ps

module tb_debug_unit;

    localparam int ADDR_W  = 5;
    localparam int MAX_CYC = 4000;  // ~200 instructions of up to 15 cycles, plus margin

    logic                        clk;
    logic                        rst_n;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [ADDR_W-1:0]           wb_adr;
    logic [31:0]                 wb_dat_w;
    logic [3:0]                  wb_sel;
    logic [31:0]                 wb_dat_r;
    logic                        wb_ack;
    dbg_pkg::retire_t            retire;
    dbg_pkg::mem_wr_t            mem_wr;
    logic [31:0]                 cs_limit;
    logic [3:0]                  exe_debug_read;
    logic                        debug_prepare;
    dbg_pkg::dbg_event_t         debug_event;

    // expected state of the unit
    int                          seed = 32'h02bf50cf;
    int                          n_mismatch = 0;
    int                          n_fail = 0;
    int                          cycles = 0;
    logic [3:0][31:0]            bp_m = '0;  // DR0..DR3
    logic [31:0]                 dr7_m = '0;
    logic [31:0]                 dr6_m = '0;
    logic                        step_m = 1'b0;
    logic                        exp_prepare = 1'b0;
    dbg_pkg::dbg_event_t         exp_event = '0;
    logic                        ev_due = 1'b0;
    dbg_pkg::dbg_event_t         ev_exp = '0;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    debug_unit_top #(.ADDR_W(ADDR_W)) i_debug_unit_top (.*);

    // --------------------------------------------------------------------------
    // reference model
    // --------------------------------------------------------------------------
    function automatic logic [2:0] ref_len_mask(input logic [1:0] len);
        return (len == 2'b10) ? 3'd7 : {1'b0, len[1], |len};  // 1, 2, 8, 4 bytes
    endfunction

    function automatic logic [3:0] en_mask(input logic [31:0] dr7);
        logic [3:0] en;
        for (int i = 0; i < 4; i++) en[i] = dr7[2*i] | dr7[2*i+1];  // L or G
        return en;  // all zero covers the global disable too
    endfunction

    function automatic logic [3:0] expect_code(input logic [31:0] lin, input logic [31:0] eip,
                                               input logic [31:0] limit, input logic blocked);
        logic [3:0]  hit;
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m      = {29'd0, ref_len_mask(dr7_m[18+4*i +: 2])};
            hit[i] = dr7_m[16+4*i +: 2] == 2'b00 && (lin | m) == (bp_m[i] | m);
        end
        return (eip > limit || blocked) ? 4'h0 : hit & en_mask(dr7_m);
    endfunction

    function automatic logic [3:0] expect_write(input logic [31:0] start, input logic [2:0] len);
        logic [3:0]  hit;
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m      = {29'd0, ref_len_mask(dr7_m[18+4*i +: 2])};
            hit[i] = dr7_m[16+4*i +: 2] == 2'b01 &&      // write only
                     start <= (bp_m[i] | m) && start + len - 1 >= (bp_m[i] & ~m);
        end
        return hit & en_mask(dr7_m);
    endfunction

    function automatic logic expect_prepare(input logic inh, input logic task_sw,
                                            input logic step, input logic [3:0] hits);
        return !inh && (task_sw || step || |hits);
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0] sel);
        for (int b = 0; b < 4; b++) if (sel[b]) old_val[8*b +: 8] = new_val[8*b +: 8];
        return old_val;
    endfunction

    // --------------------------------------------------------------------------
    // compare tasks
    // --------------------------------------------------------------------------
    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_event(input dbg_pkg::dbg_event_t got, input dbg_pkg::dbg_event_t exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t ns: debug event got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // --------------------------------------------------------------------------
    // wishbone driver
    // --------------------------------------------------------------------------
    task automatic wb_xfer(input logic we, input int word, input logic [31:0] data,
                           input logic [3:0] sel, output logic [31:0] rdata);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= ADDR_W'(word * 4);  // byte address
        wb_dat_w <= data;
        wb_sel   <= sel;
        do @(posedge clk); while (!wb_ack);
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input int word, input logic [31:0] data, input logic [3:0] sel);
        logic [31:0] unused;
        wb_xfer(1'b1, word, data, sel, unused);
        if (word < 4) bp_m[word] = merge_lanes(bp_m[word], data, sel);
        if (word == 6) dr6_m = merge_lanes(dr6_m, data, sel) & 32'h0000_c00f;  // BT, BS, B3..B0
        if (word == 7) dr7_m = merge_lanes(dr7_m, data, sel);
    endtask

    task automatic wb_read(input int word, output logic [31:0] rdata);
        wb_xfer(1'b0, word, 32'h0, 4'h0, rdata);
    endtask

    task automatic check_dr6();
        logic [31:0] rdata;
        wb_read(6, rdata);
        check_word(rdata, dr6_m, "DR6 after events");
        wb_write(6, 32'h0, 4'hf);
        wb_read(6, rdata);
        check_word(rdata, dr6_m, "DR6 after clear");
    endtask

    task automatic program_bps(input logic [15:0] rw_len, input logic [7:0] enables);
        for (int i = 0; i < 4; i++) wb_write(i, 32'h0001_0000 + ($random(seed) & 32'hfff), 4'hf);
        wb_write(7, {rw_len, 8'h00, enables}, 4'hf);
    endtask

    // --------------------------------------------------------------------------
    // one instruction, three load cycles, finish, then an idle cycle
    // --------------------------------------------------------------------------
    task automatic run_instr(input dbg_pkg::retire_t fin, input logic has_wr,
                             input logic [31:0] wa, input logic [2:0] wl,
                             input logic [2:0][3:0] rd, input logic clr);
        dbg_pkg::retire_t    idle;
        dbg_pkg::dbg_event_t ev;
        logic [3:0]          rd_hits;
        logic                p;
        idle         = '0;
        idle.eip     = fin.eip;
        idle.cs_base = fin.cs_base;
        idle.w_load  = 1'b1;
        rd_hits      = '0;
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            retire         <= idle;
            mem_wr         <= '{write_address: wa, write_length: wl, write_ready: has_wr && c == 2};
            exe_debug_read <= rd[c];
            rd_hits        = rd_hits | rd[c];
        end
        @(posedge clk);
        fin.wr_finished = 1'b1;
        retire         <= fin;  // write_ready stays up through finish
        exe_debug_read <= '0;
        ev.code    = expect_code(fin.cs_base + fin.eip, fin.eip, cs_limit,
                                 fin.rflag | fin.string_in_progress);
        ev.write   = has_wr ? expect_write(wa, wl) : 4'h0;
        ev.read    = rd_hits & en_mask(dr7_m);
        ev.step    = step_m;
        ev.task_sw = fin.task_trigger;
        p = expect_prepare(fin.inhibit, ev.task_sw, ev.step, ev.code | ev.write | ev.read);
        exp_prepare <= p;
        exp_event   <= ev;
        if (p) begin
            dr6_m[3:0] = dr6_m[3:0] | ev.code | ev.write | ev.read;
            dr6_m[14]  = dr6_m[14] | ev.step;
            dr6_m[15]  = dr6_m[15] | ev.task_sw;
        end
        step_m = fin.tflag;  // armed for the next finish
        @(posedge clk);
        idle.w_load     = 1'b0;
        idle.trap_clear = clr;  // exception entry
        retire             <= idle;
        mem_wr.write_ready <= 1'b0;
        if (clr) step_m = 1'b0;
    endtask

    // --------------------------------------------------------------------------
    // monitor and timeout
    // --------------------------------------------------------------------------
    always @(posedge clk) begin
        if (ev_due) check_event(debug_event, ev_exp);
        ev_due <= 1'b0;
        if (rst_n && retire.wr_finished) begin
            check_bit(debug_prepare, exp_prepare, "debug_prepare");
            if (debug_prepare) begin
                ev_due <= 1'b1;
                ev_exp <= exp_event;
            end
        end else if (rst_n && debug_prepare) begin
            n_fail++;
            $display("error at %0t ns: debug_prepare rose outside a finish cycle", $time);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYC) begin
            $display("timeout: run still going after %0d cycles", MAX_CYC);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // --------------------------------------------------------------------------
    // stimulus
    // --------------------------------------------------------------------------
    initial begin
        logic [31:0]      rdata;
        logic [31:0]      data;
        logic [31:0]      lin;
        logic [3:0]       sel;
        logic [2:0][3:0]  rd;
        dbg_pkg::retire_t fin;
        int               word;
        int               k;
        rst_n          = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        wb_sel         = '0;
        retire         = '0;
        mem_wr         = '0;
        cs_limit       = 32'hffff_ffff;
        exe_debug_read = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // register access, DR6 left out here
        for (int n = 0; n < 24; n++) begin
            word = n % 8;
            if (word == 6) word = 4;
            data = $random(seed);
            sel  = 4'($random(seed));
            wb_write(word, data, sel);
            wb_read(word, rdata);
            check_word(rdata, (word < 4) ? bp_m[word] : (word == 7) ? dr7_m : 32'h0, "register");
        end
        check_dr6();

        // code breakpoints, RW forced to execute
        for (int n = 0; n < 40; n++) begin
            if (n % 10 == 0) program_bps(16'($random(seed)) & 16'hcccc,
                                         (n == 30) ? 8'h00 : 8'($random(seed)));
            k           = $random(seed) & 3;
            fin         = '0;
            fin.cs_base = $random(seed) & 32'h0000_7f00;
            lin         = (n % 4 == 3) ? 32'($random(seed)) : bp_m[k] + ($random(seed) & 7);
            fin.eip     = lin - fin.cs_base;
            fin.rflag   = ($random(seed) & 7) == 0;
            fin.string_in_progress = ($random(seed) & 7) == 0;
            cs_limit <= (($random(seed) & 7) == 0) ? fin.eip - 1 : 32'hffff_ffff;
            run_instr(fin, 1'b0, '0, 3'd1, '0, 1'b1);
        end
        cs_limit <= 32'hffff_ffff;
        check_dr6();

        // write breakpoints, any RW
        for (int n = 0; n < 40; n++) begin
            if (n % 10 == 0) program_bps(16'($random(seed)), 8'($random(seed)));
            k       = $random(seed) & 3;
            fin     = '0;
            fin.eip = $random(seed);
            run_instr(fin, 1'b1, bp_m[k] + ($random(seed) & 15) - 6,
                      3'(1 + ($random(seed) & 3)), '0, 1'b1);
        end
        check_dr6();

        // read hits over the load cycles
        program_bps(16'($random(seed)), 8'($random(seed)));
        for (int n = 0; n < 20; n++) begin
            fin     = '0;
            fin.eip = $random(seed);
            for (int c = 0; c < 3; c++) rd[c] = 4'($random(seed));
            run_instr(fin, 1'b0, '0, 3'd1, rd, 1'b1);
        end
        check_dr6();

        // single step, task switch, inhibit, trap clear with breakpoints off
        wb_write(7, 32'h0, 4'hf);
        for (int n = 0; n < 30; n++) begin
            fin              = '0;
            fin.eip          = $random(seed);
            fin.tflag        = $random(seed) & 1;
            fin.task_trigger = ($random(seed) & 3) == 0;
            fin.inhibit      = ($random(seed) & 3) == 0;
            run_instr(fin, 1'b0, '0, 3'd1, '0, ($random(seed) & 3) == 0);
        end
        check_dr6();

        repeat (3) @(posedge clk);  // last event check
        $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
        if (n_mismatch == 0 && n_fail == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/dbg_pkg.sv
hw/dbg_regs.sv
hw/bp_match.sv
hw/write_debug.sv
hw/debug_unit_top.sv
test/tb_debug_unit.sv

/* Bender.yml */
package:
  name: debug_unit

sources:
  - files:
      - hw/dbg_pkg.sv
      - hw/dbg_regs.sv
      - hw/bp_match.sv
      - hw/write_debug.sv
      - hw/debug_unit_top.sv
  - target: test
    files:
      - test/tb_debug_unit.sv
